// ==== credit_link_consts.svh ====
// Shared sizing constants for the credit-controlled flit link.
// Include in any file that needs flit, FIFO or credit sizes.
// FIFO depth doubles as the producer's initial credit budget.

`ifndef CREDIT_LINK_CONSTS_SVH
`define CREDIT_LINK_CONSTS_SVH

// Bits per flit
`define CL_FLIT_WIDTH 16

// FIFO entries, also producer credits after reset
`define CL_DEPTH 8

// Most read credits the consumer may hold outstanding
`define CL_RX_CREDIT_MAX 8

// Header length field width
`define CL_LEN_WIDTH 4

`endif

// ==== credit_link_pkg.sv ====
// Types shared by the flit link modules.
// A flit is a single word with two views, picked by the is_header bit.
// Also carries the FIFO status pair sent to the control block.

`include "credit_link_consts.svh"

package credit_link_pkg;

  // Header view
  typedef struct packed {
    logic                                   is_header;
    logic [2:0]                             dest;
    logic [`CL_LEN_WIDTH-1:0]               length;
    logic [`CL_FLIT_WIDTH-4-`CL_LEN_WIDTH-1:0] spare;
  } flit_header_t;

  // Payload view, is_header clear
  typedef struct packed {
    logic                      is_header;
    logic [`CL_FLIT_WIDTH-2:0] data;
  } flit_payload_t;

  // Same 16 bits, decoded either way
  typedef union packed {
    flit_header_t  header;
    flit_payload_t payload;
  } flit_t;

  // FIFO flags for the control block
  typedef struct packed {
    logic full;
    logic empty;
  } fifo_status_t;

endpackage

// ==== sync_fifo.sv ====
// Circular FIFO holding the queued flits of the link.
// Head entry is shown ahead on read_flit, no read latency.
// push and pop come pre-gated from the control block, so no
// overflow or underflow protection lives here.

`timescale 1ns/1ps
`include "credit_link_consts.svh"

module sync_fifo (
  input  logic                          clock,
  input  logic                          resetn,
  input  logic                          push,
  input  logic                          pop,
  input  credit_link_pkg::flit_t        write_flit,
  output credit_link_pkg::flit_t        read_flit,
  output credit_link_pkg::fifo_status_t status
);

  import credit_link_pkg::*;

  localparam int PTR_WIDTH   = $clog2(`CL_DEPTH);
  localparam int COUNT_WIDTH = $clog2(`CL_DEPTH + 1);
  localparam logic [PTR_WIDTH-1:0]   LAST_INDEX = PTR_WIDTH'(`CL_DEPTH - 1);
  localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(`CL_DEPTH);

  // Storage, no reset needed on payload
  flit_t mem [`CL_DEPTH];

  logic [PTR_WIDTH-1:0]   write_ptr;
  logic [PTR_WIDTH-1:0]   read_ptr;
  logic [COUNT_WIDTH-1:0] count;

  always_ff @(posedge clock) begin
    if (push) begin
      mem[write_ptr] <= write_flit;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= '0;
    end else begin
      if (push) begin
        write_ptr <= (write_ptr == LAST_INDEX) ? '0 : write_ptr + 1'b1;
      end
      if (pop) begin
        read_ptr <= (read_ptr == LAST_INDEX) ? '0 : read_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Show-ahead head entry
  assign read_flit = mem[read_ptr];

  always_comb begin
    status.full  = (count == FULL_COUNT);
    status.empty = (count == '0);
  end

endmodule

// ==== credit_counter.sv ====
// Saturating up/down counter for read credits granted by the consumer.
// up adds a credit, down spends one, both together cancel.
// has_credit tells the control block a read may go out this cycle.

`timescale 1ns/1ps

module credit_counter #(
  parameter int MAX = 8
) (
  input  logic clock,
  input  logic resetn,
  input  logic up,
  input  logic down,
  output logic has_credit
);

  localparam int WIDTH = $clog2(MAX + 1);
  localparam logic [WIDTH-1:0] MAX_COUNT = WIDTH'(MAX);

  logic [WIDTH-1:0] count;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      // No credits until the consumer grants some
      count <= '0;
    end else begin
      if (up && !down) begin
        // Stick at MAX instead of wrapping
        if (count != MAX_COUNT) begin
          count <= count + 1'b1;
        end
      end else if (down && !up) begin
        if (count != '0) begin
          count <= count - 1'b1;
        end
      end
    end
  end

  // Straight from the count, same cycle
  assign has_credit = (count != '0);

endmodule

// ==== packet_tracker.sv ====
// Follows packets on the output side of the link.
// Header flits load the payload length, payload flits count it down.
// last marks the final flit of a packet in the cycle it transfers,
// and packet_count bumps on that same edge.

`timescale 1ns/1ps
`include "credit_link_consts.svh"

module packet_tracker (
  input  logic                   clock,
  input  logic                   resetn,
  input  logic                   flit_valid,
  input  credit_link_pkg::flit_t flit,
  output logic                   last,
  output logic [15:0]            packet_count
);

  // Payload flits still owed by the current packet
  logic [`CL_LEN_WIDTH-1:0] remaining;
  logic                     header_seen;

  assign header_seen = flit.header.is_header;

  // Zero-length header closes its own packet
  always_comb begin
    last = 1'b0;
    if (flit_valid) begin
      if (header_seen) begin
        last = (flit.header.length == '0);
      end else begin
        last = (remaining == `CL_LEN_WIDTH'(1));
      end
    end
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      remaining    <= '0;
      packet_count <= '0;
    end else begin
      if (flit_valid) begin
        if (header_seen) begin
          remaining <= flit.header.length;
        end else if (remaining != '0) begin
          remaining <= remaining - 1'b1;
        end
      end
      // One packet done per last flit
      if (last) begin
        packet_count <= packet_count + 16'd1;
      end
    end
  end

endmodule

// ==== credit_link_control.sv ====
// Flow control for the link buffer.
// Gates producer writes on FIFO full, consumer reads on FIFO not empty
// and held read credit. Returns one write credit to the producer a
// cycle after each read and latches a sticky overrun flag.

`timescale 1ns/1ps

module credit_link_control (
  input  logic                          clock,
  input  logic                          resetn,
  input  logic                          in_valid,
  input  credit_link_pkg::fifo_status_t status,
  input  logic                          has_credit,
  input  logic                          out_credit,
  output logic                          push,
  output logic                          pop,
  output logic                          credit_up,
  output logic                          credit_down,
  output logic                          in_credit,
  output logic                          overrun
);

  logic write_dropped;

  // Write lands unless the buffer is full
  assign push = in_valid && !status.full;

  // Write into a full buffer loses the flit
  assign write_dropped = in_valid && status.full;

  // Read needs data and a consumer credit
  assign pop = !status.empty && has_credit;

  // Consumer grants raise, reads spend
  assign credit_up   = out_credit;
  assign credit_down = pop;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      in_credit <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      // Freed slot goes back to the producer next cycle
      in_credit <= pop;
      if (write_dropped) begin
        overrun <= 1'b1;
      end
    end
  end

endmodule

// ==== credit_link_top.sv ====
// Credit-controlled flit link buffer, top level.
// Producer writes strobed flits against its own credits, the consumer
// pulls them out by granting read credits on out_credit.
// Ties together control, FIFO, read credit counter and packet tracker.

`timescale 1ns/1ps
`include "credit_link_consts.svh"

module credit_link_top (
  input  logic                   clock,
  input  logic                   resetn,
  input  logic                   in_valid,
  input  credit_link_pkg::flit_t in_flit,
  output logic                   in_credit,
  input  logic                   out_credit,
  output logic                   out_valid,
  output credit_link_pkg::flit_t out_flit,
  output logic                   out_last,
  output logic [15:0]            packet_count,
  output logic                   overrun
);

  import credit_link_pkg::*;

  fifo_status_t status;
  logic         push;
  logic         credit_up;
  logic         credit_down;
  logic         has_credit;

  // Read strobe is the output valid
  credit_link_control control (
    .clock       (clock),
    .resetn      (resetn),
    .in_valid    (in_valid),
    .status      (status),
    .has_credit  (has_credit),
    .out_credit  (out_credit),
    .push        (push),
    .pop         (out_valid),
    .credit_up   (credit_up),
    .credit_down (credit_down),
    .in_credit   (in_credit),
    .overrun     (overrun)
  );

  sync_fifo fifo (
    .clock      (clock),
    .resetn     (resetn),
    .push       (push),
    .pop        (out_valid),
    .write_flit (in_flit),
    .read_flit  (out_flit),
    .status     (status)
  );

  // Consumer side read credits
  credit_counter #(
    .MAX (`CL_RX_CREDIT_MAX)
  ) rx_credits (
    .clock      (clock),
    .resetn     (resetn),
    .up         (credit_up),
    .down       (credit_down),
    .has_credit (has_credit)
  );

  packet_tracker tracker (
    .clock        (clock),
    .resetn       (resetn),
    .flit_valid   (out_valid),
    .flit         (out_flit),
    .last         (out_last),
    .packet_count (packet_count)
  );

endmodule

// ==== credit_link_assertions.sv ====
// Concurrent checks on the flit link, bound into credit_link_top.
// Covers read gating, credit return timing and the overrun flag.
// Failures bump error_count, which the testbench polls.

`timescale 1ns/1ps

module credit_link_assertions (
  input logic                          clock,
  input logic                          resetn,
  input logic                          in_valid,
  input credit_link_pkg::fifo_status_t status,
  input logic                          out_credit,
  input logic                          out_valid,
  input logic                          in_credit,
  input logic                          out_last,
  input logic                          overrun
);

  // Failing properties so far
  int   error_count = 0;
  // Set by the first consumer grant after reset
  logic credit_granted;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      credit_granted <= 1'b0;
    end else if (out_credit) begin
      credit_granted <= 1'b1;
    end
  end

  // Nothing leaves before the consumer has granted anything
  no_read_before_grant: assert property (@(posedge clock) disable iff (!resetn)
    !credit_granted |-> !out_valid)
    else begin
      error_count = error_count + 1;
      $error("out_valid high before any out_credit pulse");
    end

  // One write credit back per read, one cycle later
  credit_return: assert property (@(posedge clock) disable iff (!resetn)
    out_valid |=> in_credit)
    else begin
      error_count = error_count + 1;
      $error("in_credit missing after a read");
    end

  no_spurious_credit: assert property (@(posedge clock) disable iff (!resetn)
    !out_valid |=> !in_credit)
    else begin
      error_count = error_count + 1;
      $error("in_credit pulse without a read");
    end

  last_only_on_read: assert property (@(posedge clock) disable iff (!resetn)
    out_last |-> out_valid)
    else begin
      error_count = error_count + 1;
      $error("out_last high without out_valid");
    end

  // Sticky once set
  overrun_sticky: assert property (@(posedge clock) disable iff (!resetn)
    overrun |=> overrun)
    else begin
      error_count = error_count + 1;
      $error("overrun cleared after being set");
    end

  // Only a write into a full FIFO may raise it
  overrun_cause: assert property (@(posedge clock) disable iff (!resetn)
    (!overrun && !(in_valid && status.full)) |=> !overrun)
    else begin
      error_count = error_count + 1;
      $error("overrun set without a write into a full FIFO");
    end

endmodule

bind credit_link_top credit_link_assertions checks (
  .clock      (clock),
  .resetn     (resetn),
  .in_valid   (in_valid),
  .status     (status),
  .out_credit (out_credit),
  .out_valid  (out_valid),
  .in_credit  (in_credit),
  .out_last   (out_last),
  .overrun    (overrun)
);

// ==== credit_link_tb.sv ====
// Testbench for the credit-controlled flit link buffer.
// Random packets go in under the producer credit rule while the consumer
// grants read credits in bursts. A scoreboard checks flit order, last
// marks, packet count and credit return. A final phase forces an overrun.

`timescale 1ns/1ps
`include "credit_link_consts.svh"

module credit_link_tb;

  import credit_link_pkg::*;

  // 60 packets of up to 16 flits, about 2 cycles per flit, plus slack
  localparam int NUM_PACKETS    = 60;
  localparam int TIMEOUT_CYCLES = 4000;

  logic        clock;
  logic        resetn;
  logic        in_valid;
  flit_t       in_flit;
  logic        in_credit;
  logic        out_credit;
  logic        out_valid;
  flit_t       out_flit;
  logic        out_last;
  logic [15:0] packet_count;
  logic        overrun;

  integer      seed;
  int          prod_credits;
  int          rx_credits;
  int          cycle_count;
  int          p;
  logic        grant_enable;
  logic        prev_out_valid;
  logic [15:0] lasts_seen;
  // Zero-length header queued before the first grant
  flit_t       early_flit;
  // Reference queue of flits and last marks in write order
  flit_t       exp_flits[$];
  logic        exp_lasts[$];
  flit_t       exp_flit;
  logic        exp_last;

  credit_link_top UUT (
    .clock        (clock),
    .resetn       (resetn),
    .in_valid     (in_valid),
    .in_flit      (in_flit),
    .in_credit    (in_credit),
    .out_credit   (out_credit),
    .out_valid    (out_valid),
    .out_flit     (out_flit),
    .out_last     (out_last),
    .packet_count (packet_count),
    .overrun      (overrun)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic end_in_failure();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, exp);
    end_in_failure();
  endtask

  task automatic plain_failure(input string msg);
    $display("%s", msg);
    end_in_failure();
  endtask

  // One flit, sent once a producer credit is free, with random gaps
  task automatic send_flit(input flit_t flit, input logic last);
    logic        sent;
    logic [31:0] rnd;
    sent = 1'b0;
    while (!sent) begin
      @(posedge clock);
      #1;
      rnd = $random(seed);
      in_valid = 1'b0;
      if (prod_credits > 0 && rnd[1:0] != 2'b00) begin
        in_valid = 1'b1;
        in_flit = flit;
        prod_credits = prod_credits - 1;
        exp_flits.push_back(flit);
        exp_lasts.push_back(last);
        sent = 1'b1;
      end
    end
  endtask

  // Header with random length, then that many payload flits
  task automatic send_packet();
    flit_t       flit;
    logic [31:0] rnd;
    int          len;
    int          i;
    rnd = $random(seed);
    len = int'(rnd[3:0]);
    flit.header.is_header = 1'b1;
    flit.header.dest      = rnd[6:4];
    flit.header.length    = rnd[3:0];
    flit.header.spare     = rnd[15:8];
    // Zero-length header closes its own packet
    send_flit(flit, len == 0);
    for (i = 1; i <= len; i++) begin
      rnd = $random(seed);
      flit.payload.is_header = 1'b0;
      flit.payload.data      = rnd[14:0];
      send_flit(flit, i == len);
    end
  endtask

  // Starve reads, fill the FIFO, then write once more past the credit rule
  task automatic fill_and_overrun();
    flit_t flit;
    int    quiet;
    quiet = 0;
    grant_enable = 1'b0;
    flit = '0;
    flit.header.is_header = 1'b1;
    // Zero-length headers until no credit is left on either side
    while (quiet < 3) begin
      @(posedge clock);
      #1;
      in_valid = 1'b0;
      if (prod_credits > 0) begin
        in_valid = 1'b1;
        in_flit = flit;
        prod_credits = prod_credits - 1;
        exp_flits.push_back(flit);
        exp_lasts.push_back(1'b1);
        quiet = 0;
      end else if (rx_credits == 0) begin
        quiet = quiet + 1;
      end else begin
        quiet = 0;
      end
    end
    // Full and no read credit, so nothing moves
    repeat (4) begin
      @(negedge clock);
      if (out_valid !== 1'b0) value_mismatch("out_valid", {31'h0, out_valid}, 32'h0);
      if (in_credit !== 1'b0) value_mismatch("in_credit", {31'h0, in_credit}, 32'h0);
    end
    if (overrun !== 1'b0) value_mismatch("overrun", {31'h0, overrun}, 32'h0);
    // Dropped flit, kept out of the reference queue
    @(posedge clock);
    #1;
    in_valid = 1'b1;
    in_flit = {1'b1, 3'h7, 4'h0, 8'hdd};
    @(posedge clock);
    #1;
    in_valid = 1'b0;
    @(negedge clock);
    if (overrun !== 1'b1) value_mismatch("overrun", {31'h0, overrun}, 32'h1);
  endtask

  // Consumer grants in random bursts, never past the counter limit
  initial begin : consumer
    int          burst_left;
    logic        granting;
    logic [31:0] rnd;
    burst_left = 0;
    granting = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      if (burst_left == 0) begin
        rnd = $random(seed);
        burst_left = int'(rnd[2:0]) + 1;
        granting = rnd[3] | rnd[4];
      end
      burst_left = burst_left - 1;
      out_credit = grant_enable && granting && rx_credits < `CL_RX_CREDIT_MAX;
    end
  end

  // Scoreboard, sampled mid-cycle with all DUT outputs settled
  always @(negedge clock) begin
    if (resetn) begin
      if (UUT.checks.error_count != 0) plain_failure("Bound assertion checker fired");
      if (in_credit !== prev_out_valid) begin
        value_mismatch("in_credit", {31'h0, in_credit}, {31'h0, prev_out_valid});
      end
      if (in_credit) prod_credits = prod_credits + 1;
      if (prod_credits < 0 || prod_credits > `CL_DEPTH) begin
        plain_failure("Producer credit count left its legal range");
      end
      if (packet_count !== lasts_seen) begin
        value_mismatch("packet_count", {16'h0, packet_count}, {16'h0, lasts_seen});
      end
      if (out_valid) begin
        if (rx_credits == 0) plain_failure("out_valid high with no read credit granted");
        if (exp_flits.size() == 0) plain_failure("Flit read with nothing queued");
        exp_flit = exp_flits.pop_front();
        exp_last = exp_lasts.pop_front();
        if (out_flit !== exp_flit) begin
          value_mismatch("out_flit", {16'h0, out_flit}, {16'h0, exp_flit});
        end
        if (out_last !== exp_last) begin
          value_mismatch("out_last", {31'h0, out_last}, {31'h0, exp_last});
        end
        if (exp_last) lasts_seen = lasts_seen + 16'd1;
        rx_credits = rx_credits - 1;
      end
      if (out_credit) rx_credits = rx_credits + 1;
      prev_out_valid = out_valid;
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) plain_failure("Timeout, run exceeded its cycle limit");
  end

  initial begin
    seed = 32'h2bde;
    resetn = 1'b0;
    in_valid = 1'b0;
    in_flit = '0;
    out_credit = 1'b0;
    grant_enable = 1'b0;
    prod_credits = `CL_DEPTH;
    rx_credits = 0;
    cycle_count = 0;
    prev_out_valid = 1'b0;
    lasts_seen = '0;
    repeat (3) @(posedge clock);
    #1;
    resetn = 1'b1;
    // Early writes queue up until the first grant
    early_flit = '0;
    early_flit.header.is_header = 1'b1;
    repeat (4) begin
      send_flit(early_flit, 1'b1);
    end
    grant_enable = 1'b1;
    for (p = 0; p < NUM_PACKETS; p++) begin
      send_packet();
    end
    fill_and_overrun();
    // Drain everything, credits must come back in full
    grant_enable = 1'b1;
    while (exp_flits.size() != 0 || prod_credits != `CL_DEPTH) begin
      @(posedge clock);
      #1;
    end
    repeat (4) @(negedge clock);
    if (overrun !== 1'b1) value_mismatch("overrun", {31'h0, overrun}, 32'h1);
    if (UUT.checks.error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      plain_failure("Bound assertion checker fired");
    end
  end

endmodule

// ==== files.f ====
+incdir+.
credit_link_pkg.sv
sync_fifo.sv
credit_counter.sv
packet_tracker.sv
credit_link_control.sv
credit_link_top.sv
credit_link_assertions.sv
credit_link_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= credit_link_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
